// File: snn.f
+incdir+common
+incdir+test
common/snn_pkg.sv
verilog/synapse_current.sv
verilog/lif_neuron_array.sv
hebbian/hebbian_learning.sv
verilog/snn_top.sv
test/snn_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f snn.f --top-module snn_tb -o snn_sim || exit 1

./obj_dir/snn_sim | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// File: test/snn_model.svh
`ifndef SNN_MODEL_SVH
`define SNN_MODEL_SVH

`include "snn_consts.svh"

// Reference network state, kept beside the DUT
int              model_v [`SNN_N];
bit [`SNN_N-1:0] model_spikes;
int              model_w [`SNN_N][`SNN_N];
int              model_last_weight;

function automatic void model_reset();
    for (int i = 0; i < `SNN_N; i++) begin
        model_v[i] = 0;
        for (int j = 0; j < `SNN_N; j++) begin
            model_w[i][j] = 0;
        end
    end
    model_spikes      = '0;
    model_last_weight = 0;
endfunction

// One timestep: drive from previous spikes, leak, integrate, fire
function automatic void model_step(input snn_pkg::stim_t stim_vec);
    int              v_max;
    int              cur;
    int              v;
    bit [`SNN_N-1:0] fired;

    v_max = (1 << `SNN_V_W) - 1;
    fired = '0;
    for (int i = 0; i < `SNN_N; i++) begin
        cur = int'(stim_vec[i]);
        for (int j = 0; j < `SNN_N; j++) begin
            if (model_spikes[j]) begin
                cur = cur + model_w[j][i];
            end
        end
        if (cur < 0) begin
            cur = 0;
        end else if (cur > v_max) begin
            cur = v_max;
        end
        v = model_v[i] - (model_v[i] >> `SNN_LEAK_SHIFT) + cur;
        if (v > v_max) begin
            v = v_max;
        end
        if (v >= `SNN_THRESHOLD) begin
            fired[i]   = 1'b1;
            model_v[i] = 0;
        end else begin
            model_v[i] = v;
        end
    end
    model_spikes = fired;
endfunction

// Strengthen k -> k+1 for each neuron k that fired
function automatic void model_sweep(input bit [`SNN_N-1:0] fired);
    for (int k = 0; k < `SNN_N - 1; k++) begin
        if (fired[k] && model_w[k][k+1] < `SNN_WEIGHT_MAX) begin
            model_w[k][k+1]   = model_w[k][k+1] + 1;
            model_last_weight = model_w[k][k+1];
        end
    end
endfunction

`endif

// File: test/snn_tb.sv
`timescale 1ns/1ps

`include "snn_consts.svh"

module snn_tb;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int WAIT_VALID     = 0;
    localparam int WAIT_DONE      = 1;
    localparam int WAIT_ACTIVE    = 2;

    logic                    clk;
    logic                    reset_n;
    snn_pkg::stim_t          stim;
    logic                    step;
    logic                    learning_enable;
    snn_pkg::spike_event_t   spike_out;
    snn_pkg::weight_matrix_t weights;
    snn_pkg::learn_status_t  learn_status;
    snn_pkg::weight_matrix_t snapshot;
    integer                  seed;

    `include "snn_model.svh"

    snn_top u_snn_top (
        .clk             (clk),
        .reset_n         (reset_n),
        .stim            (stim),
        .step            (step),
        .learning_enable (learning_enable),
        .spike_out       (spike_out),
        .weights         (weights),
        .learn_status    (learn_status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Value check failed");
        end
    endtask

    // Weights against the model or against the held copy
    task automatic compare_weights(input bit frozen);
        for (int i = 0; i < `SNN_N; i++) begin
            for (int j = 0; j < `SNN_N; j++) begin
                check_value($sformatf("weights[%0d][%0d]", i, j),
                            frozen ? int'(snapshot[i][j]) : model_w[i][j],
                            int'(weights[i][j]));
            end
        end
    endtask

    task automatic wait_for(input int sel, input string what);
        bit seen;

        seen = 1'b0;
        for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
            @(negedge clk);
            case (sel)
                WAIT_VALID: seen = spike_out.valid;
                WAIT_DONE:  seen = learn_status.sweep_done;
                default:    seen = learn_status.active;
            endcase
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
            $display("SIMULATION FAILED");
            $fatal(1, "Wait timed out");
        end
    endtask

    function automatic snn_pkg::stim_t build_stim(input bit [`SNN_N-1:0] mask, input bit rnd);
        snn_pkg::stim_t s;
        int             r;

        s = '0;
        for (int i = 0; i < `SNN_N; i++) begin
            r = $random(seed);
            if (mask[i]) begin
                s[i] = rnd ? r[3:0] : 4'hf;
            end
        end
        return s;
    endfunction

    // Step the network once and mirror the sweep in the model after the latch
    task automatic run_step(input snn_pkg::stim_t s);
        @(posedge clk);
        #2;
        stim = s;
        step = 1'b1;
        model_step(s);
        @(posedge clk);
        #2;
        step = 1'b0;
        wait_for(WAIT_VALID, "spike_out.valid");
        @(posedge clk);
        #2;
        if (learning_enable) begin
            model_sweep(model_spikes);
        end
    endtask

    // Spikes on each valid pulse, weights and last_weight on each sweep_done
    always @(negedge clk) begin
        if (reset_n && spike_out.valid) begin
            check_value("spike_out.spikes", int'(model_spikes), int'(spike_out.spikes));
            compare_weights(1'b0);
        end
        if (reset_n && learn_status.sweep_done) begin
            compare_weights(1'b0);
            check_value("learn_status.last_weight", model_last_weight,
                        int'(learn_status.last_weight));
        end
    end

    initial begin
        seed            = 36163;
        reset_n         = 1'b0;
        stim            = '0;
        step            = 1'b0;
        learning_enable = 1'b0;
        snapshot        = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #2;
        reset_n = 1'b1;

        @(negedge clk);
        check_value("spike_out.valid", 0, int'(spike_out.valid));
        check_value("spike_out.spikes", 0, int'(spike_out.spikes));
        check_value("learn_status.sweep_done", 0, int'(learn_status.sweep_done));
        check_value("learn_status.active", 0, int'(learn_status.active));
        check_value("learn_status.last_weight", 0, int'(learn_status.last_weight));
        compare_weights(1'b0);

        // Random drive with learning off
        repeat (40) run_step(build_stim('1, 1'b1));

        // Neurons 0, 2 and 4 driven hard until forward weights saturate
        learning_enable = 1'b1;
        for (int n = 0; n < 72; n++) begin
            run_step(build_stim(7'b0010101, 1'b0));
            wait_for(WAIT_DONE, "learn_status.sweep_done");
        end
        check_value("weights[0][1]", `SNN_WEIGHT_MAX, int'(weights[0][1]));

        // Downstream neurons only see learned synaptic drive
        @(posedge clk);
        #2;
        learning_enable = 1'b0;
        repeat (30) run_step(build_stim(7'b0010101, 1'b1));

        // Pause each sweep after three neurons and let it finish
        learning_enable = 1'b1;
        for (int n = 0; n < 8; n++) begin
            for (int i = 0; i < `SNN_N; i++) begin
                for (int j = 0; j < `SNN_N; j++) begin
                    snapshot[i][j] = snn_pkg::weight_t'(model_w[i][j]);
                end
            end
            run_step(build_stim('1, 1'b0));

            // Only the first three forward synapses are updated before the pause
            for (int k = 0; k < 3; k++) begin
                snapshot[k][k+1] = snn_pkg::weight_t'(model_w[k][k+1]);
            end
            wait_for(WAIT_ACTIVE, "learn_status.active");
            repeat (5) @(posedge clk);
            #2;
            learning_enable = 1'b0;
            repeat (9) @(posedge clk);
            @(negedge clk);
            check_value("learn_status.active", 1, int'(learn_status.active));
            compare_weights(1'b1);
            @(posedge clk);
            #2;
            learning_enable = 1'b1;
            wait_for(WAIT_DONE, "learn_status.sweep_done");
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verilog/snn_top.sv
`timescale 1ns/1ps

module snn_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  snn_pkg::stim_t          stim,
    input  logic                    step,
    input  logic                    learning_enable,
    output snn_pkg::spike_event_t   spike_out,
    output snn_pkg::weight_matrix_t weights,
    output snn_pkg::learn_status_t  learn_status
);

    snn_pkg::current_t       current;
    snn_pkg::spike_event_t   spike_ev;
    snn_pkg::weight_matrix_t weights_w;

    // Previous spikes and learned weights feed back into the drive
    synapse_current u_synapse_current (
        .stim    (stim),
        .spikes  (spike_ev.spikes),
        .weights (weights_w),
        .current (current)
    );

    lif_neuron_array u_lif_neuron_array (
        .clk       (clk),
        .reset_n   (reset_n),
        .step      (step),
        .current   (current),
        .spike_out (spike_ev)
    );

    hebbian_learning u_hebbian_learning (
        .clk             (clk),
        .reset_n         (reset_n),
        .learning_enable (learning_enable),
        .spike_in        (spike_ev),
        .weights         (weights_w),
        .learn_status    (learn_status)
    );

    assign spike_out = spike_ev;
    assign weights   = weights_w;

endmodule

// File: hebbian/hebbian_learning.sv
`timescale 1ns/1ps

`include "snn_consts.svh"

module hebbian_learning (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    learning_enable,
    input  snn_pkg::spike_event_t   spike_in,
    output snn_pkg::weight_matrix_t weights,
    output snn_pkg::learn_status_t  learn_status
);

    localparam int IDX_W = `SNN_IDX_W;
    localparam snn_pkg::weight_t WEIGHT_MAX = snn_pkg::weight_t'(`SNN_WEIGHT_MAX);
    localparam snn_pkg::weight_t WEIGHT_ONE = snn_pkg::weight_t'(1);

    snn_pkg::learn_state_e   state_q;
    logic [IDX_W-1:0]        idx_q;
    logic [`SNN_N-1:0]       spk_q;
    snn_pkg::weight_matrix_t weights_q;
    logic signed [7:0]       last_weight_q;
    logic                    sweep_done_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q       <= snn_pkg::IDLE;
            idx_q         <= '0;
            spk_q         <= '0;
            weights_q     <= '0;
            last_weight_q <= '0;
            sweep_done_q  <= 1'b0;
        end else begin
            sweep_done_q <= 1'b0;

            // Everything holds while learning is paused
            if (learning_enable) begin
                case (state_q)
                    snn_pkg::IDLE: begin
                        if (spike_in.valid) begin
                            spk_q   <= spike_in.spikes;
                            idx_q   <= '0;
                            state_q <= snn_pkg::UPDATE;
                        end
                    end

                    snn_pkg::UPDATE: begin
                        // Forward synapse k -> k+1 only
                        for (int k = 0; k < `SNN_N - 1; k++) begin
                            if (idx_q == IDX_W'(k) && spk_q[k] &&
                                signed'(weights_q[k][k+1]) < WEIGHT_MAX) begin
                                weights_q[k][k+1] <= weights_q[k][k+1] + WEIGHT_ONE;
                                last_weight_q <= 8'(signed'(weights_q[k][k+1])) + 8'sd1;
                            end
                        end
                        state_q <= snn_pkg::NEXT;
                    end

                    snn_pkg::NEXT: begin
                        if (idx_q == IDX_W'(`SNN_N - 1)) begin
                            state_q      <= snn_pkg::IDLE;
                            sweep_done_q <= 1'b1;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= snn_pkg::UPDATE;
                        end
                    end

                    default: begin
                        state_q <= snn_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    assign weights = weights_q;

    assign learn_status.sweep_done  = sweep_done_q;
    assign learn_status.active      = (state_q != snn_pkg::IDLE);
    assign learn_status.last_weight = last_weight_q;

endmodule

// File: verilog/lif_neuron_array.sv
`timescale 1ns/1ps

`include "snn_consts.svh"

module lif_neuron_array (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  step,
    input  snn_pkg::current_t     current,
    output snn_pkg::spike_event_t spike_out
);

    // Membrane potentials
    logic [`SNN_N-1:0][`SNN_V_W-1:0] v_q;
    logic [`SNN_N-1:0][`SNN_V_W-1:0] v_d;
    logic [`SNN_N-1:0]               spk_d;

    always_comb begin
        logic [`SNN_V_W:0]   acc;
        logic [`SNN_V_W-1:0] sat;

        acc = '0;
        sat = '0;
        for (int i = 0; i < `SNN_N; i++) begin
            // Leak then integrate, one spare bit for overflow
            acc = {1'b0, v_q[i] - (v_q[i] >> `SNN_LEAK_SHIFT)} + {1'b0, current[i]};
            sat = acc[`SNN_V_W] ? '1 : acc[`SNN_V_W-1:0];

            if (sat >= `SNN_THRESHOLD) begin
                spk_d[i] = 1'b1;
                v_d[i]   = '0;
            end else begin
                spk_d[i] = 1'b0;
                v_d[i]   = sat;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            v_q       <= '0;
            spike_out <= '0;
        end else begin
            spike_out.valid <= step;
            if (step) begin
                v_q              <= v_d;
                spike_out.spikes <= spk_d;
            end
        end
    end

endmodule

// File: verilog/synapse_current.sv
`timescale 1ns/1ps

`include "snn_consts.svh"

module synapse_current (
    input  snn_pkg::stim_t          stim,
    input  logic [`SNN_N-1:0]       spikes,
    input  snn_pkg::weight_matrix_t weights,
    output snn_pkg::current_t       current
);

    // Room for the stimulus plus N signed weights
    localparam int SUM_W = `SNN_V_W + 2;
    localparam int V_MAX = (1 << `SNN_V_W) - 1;

    always_comb begin
        logic signed [SUM_W-1:0] acc;

        acc = '0;
        current = '0;
        for (int i = 0; i < `SNN_N; i++) begin
            acc = SUM_W'(stim[i]);

            // Weighted spikes from the previous timestep
            for (int j = 0; j < `SNN_N; j++) begin
                if (spikes[j]) begin
                    acc = acc + SUM_W'(signed'(weights[j][i]));
                end
            end

            // Clamp into the unsigned membrane range
            if (acc < 0) begin
                current[i] = '0;
            end else if (acc > V_MAX) begin
                current[i] = '1;
            end else begin
                current[i] = acc[`SNN_V_W-1:0];
            end
        end
    end

endmodule

// File: common/snn_pkg.sv
`include "snn_consts.svh"

package snn_pkg;

    typedef logic signed [`SNN_WEIGHT_W-1:0] weight_t;

    // Indexed [pre][post]
    typedef weight_t [`SNN_N-1:0][`SNN_N-1:0] weight_matrix_t;

    typedef logic [`SNN_N-1:0][`SNN_STIM_W-1:0] stim_t;

    typedef logic [`SNN_N-1:0][`SNN_V_W-1:0] current_t;

    typedef struct packed {
        logic              valid;
        logic [`SNN_N-1:0] spikes;
    } spike_event_t;

    typedef enum logic [1:0] {
        IDLE,
        UPDATE,
        NEXT
    } learn_state_e;

    typedef struct packed {
        logic              sweep_done;
        logic              active;
        logic signed [7:0] last_weight;
    } learn_status_t;

endpackage

// File: common/snn_consts.svh
`ifndef SNN_CONSTS_SVH
`define SNN_CONSTS_SVH

// Network size
`define SNN_N 7

// Synaptic weights, signed
`define SNN_WEIGHT_W 4
`define SNN_WEIGHT_MAX 7

// Neuron inputs and membrane
`define SNN_STIM_W 4
`define SNN_V_W 8
`define SNN_THRESHOLD 64
`define SNN_LEAK_SHIFT 3

// Learning sweep counter
`define SNN_IDX_W 3

`endif
